//--- dsp_pio.f
+incdir+verif
src/dsp_pio_pkg.sv
src/pio_irq.sv
src/pio_port.sv
src/pio_top.sv
verif/pio_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the pio testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module pio_tb \
    -Mdir obj_dir -f dsp_pio.f > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vpio_tb > sim.log 2>&1
cat sim.log
! grep -q "Verification failed" sim.log && grep -q "Verification passed" sim.log \
    && { echo "simulation ok"; exit 0; } \
    || { echo "simulation reported errors"; exit 1; }

//--- src/dsp_pio_pkg.sv
// shared types for the dsp parallel i/o port
// register layout follows the dsp16 pioc / pdx map

package dsp_pio_pkg;

    // addressable registers, same as the low bits of the r field
    typedef enum logic [1:0] {
        REG_PIOC = 2'd0, // control and status
        REG_PDX0 = 2'd1, // peripheral 0 data
        REG_PDX1 = 2'd2  // peripheral 1 data
    } pio_reg_e;

    // cpu side operations
    typedef enum logic [1:0] {
        OP_NONE = 2'd0, // idle cycle
        OP_LOAD = 2'd1, // immediate load into pioc or pdx
        OP_READ = 2'd2  // pdx read, starts an input strobe
    } pio_op_e;

    // one cpu request, lasts a single cen cycle
    typedef struct packed {
        pio_op_e     op;
        pio_reg_e    sel;
        logic [15:0] data;  // immediate word from program memory
    } pio_req_t;

    // writable pioc bits 14 down to 5
    // bit 15 and the low status bits are not stored
    typedef struct packed {
        logic [1:0] stlen;   // strobe length minus one, in cen ticks
        logic       po_mode; // output strobe active mode
        logic       pi_mode; // input strobe active mode
        logic       scmode;  // byte mode, kept but not acted on
        logic [4:0] ien;     // interrupt enables
    } pioc_t;

    // both strobes in active mode out of reset
    localparam pioc_t PIOC_RESET = '{
        stlen:   2'd0,
        po_mode: 1'b1,
        pi_mode: 1'b1,
        scmode:  1'b0,
        ien:     5'd0
    };

    // roles of the ien bits
    localparam logic [2:0] IEN_IRQ   = 3'd0; // external irq pin
    localparam logic [2:0] IEN_SIORD = 3'd3; // serial input full
    localparam logic [2:0] IEN_SIOWR = 3'd4; // serial output empty

endpackage

//--- src/pio_irq.sv
`timescale 1ns/1ps

// interrupt latch for the pio block
// rising edges of enabled sources give a one cycle pulse on irq_latch
// runs on every clock, cen does not matter here

module pio_irq (
    input  logic       clk,
    input  logic       rst,
    input  logic       irq,         // external interrupt request
    input  logic       siord_full,  // serial input register full
    input  logic       siowr_empty, // serial output register empty
    input  logic       iack,        // interrupt acknowledge from core
    input  logic [4:0] ien,         // enables from pioc
    output logic       irq_latch
);

    // previous values
    logic last_irq;
    logic last_siord_full;
    logic last_siowr_empty;
    logic last_iack;

    // edge flags
    logic irq_rise;
    logic siord_rise;
    logic siowr_rise;
    logic iack_fall;
    logic any_rise;

    assign iack_fall  = ~iack & last_iack;               // end of acknowledge
    assign irq_rise   = irq & ~last_irq;
    assign siord_rise = siord_full & ~last_siord_full;
    assign siowr_rise = siowr_empty & ~last_siowr_empty;

    // only sources with their enable bit set count
    assign any_rise = (irq_rise   & ien[dsp_pio_pkg::IEN_IRQ])   |
                      (siord_rise & ien[dsp_pio_pkg::IEN_SIORD]) |
                      (siowr_rise & ien[dsp_pio_pkg::IEN_SIOWR]);

    // edge history
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_irq         <= 1'b0;
            last_siord_full  <= 1'b0;
            last_siowr_empty <= 1'b0;
            last_iack        <= 1'b0;
        end else begin
            last_iack        <= iack;
            // cleared on ack so a held irq level raises a fresh pulse
            last_irq         <= irq & ~iack_fall;
            last_siord_full  <= siord_full;
            last_siowr_empty <= siowr_empty;
        end
    end

    // pulse register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_latch <= 1'b0;
        end else begin
            irq_latch <= any_rise & ~iack_fall; // ack edge masks the pulse
        end
    end

endmodule

//--- src/pio_port.sv
`timescale 1ns/1ps

// parallel i/o port, active mode only
// pods_n / pids_n are always driven from here
// all state moves on clk edges with cen high

module pio_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,         // clock enable tick
    input  dsp_pio_pkg::pio_req_t req,         // cpu request
    input  dsp_pio_pkg::pio_reg_e rd_sel,      // read-back select
    input  logic [15:0]           pbus_in,     // peripheral data in
    input  logic                  irq,         // status only
    input  logic                  siord_full,  // status only
    input  logic                  siowr_empty, // status only
    output logic [15:0]           pbus_out,
    output logic                  pods_n,      // output data strobe
    output logic                  pids_n,      // input data strobe
    output logic                  psel,        // peripheral select
    output logic [4:0]            ien,         // to the interrupt block
    output logic [15:0]           pio_dout     // cpu read-back
);

    dsp_pio_pkg::pioc_t pioc;  // control register

    // strobe shift counters, bit 0 is the strobe
    logic [3:0]  pocnt;
    logic [3:0]  picnt;
    logic [3:0]  ststart;     // start pattern, stlen+1 low bits

    // capture registers
    logic [15:0] pdx0_rd;
    logic [15:0] pdx1_rd;

    // decoded request
    logic        is_pdx;
    logic        pioc_ld;
    logic        pdx_ld;
    logic        pdx_rd;
    logic        pdx_acc;
    logic        capture;
    logic [4:0]  status;

    // request decode
    assign is_pdx  = (req.sel == dsp_pio_pkg::REG_PDX0) ||
                     (req.sel == dsp_pio_pkg::REG_PDX1);
    assign pioc_ld = (req.op == dsp_pio_pkg::OP_LOAD) &&
                     (req.sel == dsp_pio_pkg::REG_PIOC);
    assign pdx_ld  = (req.op == dsp_pio_pkg::OP_LOAD) && is_pdx;
    assign pdx_rd  = (req.op == dsp_pio_pkg::OP_READ) && is_pdx; // pioc read ignored
    assign pdx_acc = pdx_ld | pdx_rd;

    // stlen 0 -> 1110, stlen 3 -> 0000
    assign ststart = 4'he << pioc.stlen;

    assign pods_n = pocnt[0];
    assign pids_n = picnt[0];
    assign ien    = pioc.ien;

    // last low tick of the input strobe, next state goes high
    assign capture = ~picnt[0] & picnt[1];

    // control register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pioc <= dsp_pio_pkg::PIOC_RESET;
        end else if (cen && pioc_ld) begin
            pioc <= req.data[14:5]; // bits 15 and 4..0 are status
        end
    end

    // strobe counters, a new access restarts a running strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pocnt <= 4'hf;
            picnt <= 4'hf;
        end else if (cen) begin
            pocnt <= pdx_ld ? ststart : {1'b1, pocnt[3:1]};
            picnt <= pdx_rd ? ststart : {1'b1, picnt[3:1]};
        end
    end

    // bus output and peripheral select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pbus_out <= 16'd0;
            psel     <= 1'b0;
        end else if (cen) begin
            if (pdx_acc) begin
                psel <= (req.sel == dsp_pio_pkg::REG_PDX1);
            end
            if (pdx_ld) begin
                pbus_out <= req.data;
            end
        end
    end

    // input capture at the end of the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pdx0_rd <= 16'd0;
            pdx1_rd <= 16'd0;
        end else if (cen && capture) begin
            if (psel) begin
                pdx1_rd <= pbus_in;
            end else begin
                pdx0_rd <= pbus_in;
            end
        end
    end

    // live status, bit 4 down to 0
    assign status = {siowr_empty, siord_full, 2'b00, irq & pioc.ien[dsp_pio_pkg::IEN_IRQ]};

    // read-back mux
    always_comb begin
        case (rd_sel)
            dsp_pio_pkg::REG_PIOC: pio_dout = {status[4], pioc, status}; // bit 15 mirrors bit 4
            dsp_pio_pkg::REG_PDX0: pio_dout = pdx0_rd;
            default:               pio_dout = pdx1_rd;
        endcase
    end

endmodule

//--- src/pio_top.sv
`timescale 1ns/1ps

// top level of the dsp parallel i/o port
// port logic plus interrupt latch

module pio_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,         // clock enable from the core
    // cpu side
    input  dsp_pio_pkg::pio_req_t req,
    input  dsp_pio_pkg::pio_reg_e rd_sel,
    output logic [15:0]           pio_dout,
    // parallel bus
    input  logic [15:0]           pbus_in,
    output logic [15:0]           pbus_out,
    output logic                  pods_n,
    output logic                  pids_n,
    output logic                  psel,
    // interrupt sources
    input  logic                  irq,
    input  logic                  siord_full,  // from the serial port
    input  logic                  siowr_empty, // from the serial port
    input  logic                  iack,
    output logic                  irq_latch
);

    logic [4:0] ien; // enables out of pioc

    // registers, strobes, capture
    pio_port port_i (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .req         (req),
        .rd_sel      (rd_sel),
        .pbus_in     (pbus_in),
        .irq         (irq),
        .siord_full  (siord_full),
        .siowr_empty (siowr_empty),
        .pbus_out    (pbus_out),
        .pods_n      (pods_n),
        .pids_n      (pids_n),
        .psel        (psel),
        .ien         (ien),
        .pio_dout    (pio_dout)
    );

    // interrupt edges, not gated by cen
    pio_irq irq_i (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .siord_full  (siord_full),
        .siowr_empty (siowr_empty),
        .iack        (iack),
        .ien         (ien),
        .irq_latch   (irq_latch)
    );

endmodule

//--- verif/pio_model.svh
`ifndef PIO_MODEL_SVH
`define PIO_MODEL_SVH

// reference state of the port
dsp_pio_pkg::pioc_t m_pioc;      // control bits 14..5
logic [15:0]        m_pbus_out;
logic [15:0]        m_pdx0;      // captured words
logic [15:0]        m_pdx1;
logic               m_psel;
int                 m_po_left;   // low cen ticks left on pods_n
int                 m_pi_left;   // same for pids_n
logic               m_last_irq;
logic               m_last_rd;
logic               m_last_wr;
logic               m_last_iack;
logic               m_latch;

task automatic reset_model();
    m_pioc      = 10'b00_1_1_0_00000; // stlen 0 with both modes set
    m_pbus_out  = 16'd0;
    m_pdx0      = 16'd0;
    m_pdx1      = 16'd0;
    m_psel      = 1'b0;
    m_po_left   = 0;
    m_pi_left   = 0;
    m_last_irq  = 1'b0;
    m_last_rd   = 1'b0;
    m_last_wr   = 1'b0;
    m_last_iack = 1'b0;
    m_latch     = 1'b0;
endtask

// one rising edge with the inputs from the last falling edge
task automatic step_model();
    logic ack_fall;
    logic rise_any;
    int   len;
    // interrupt side runs every clock on the enables before this edge
    ack_fall = m_last_iack & ~iack;
    rise_any = (irq & ~m_last_irq & m_pioc.ien[dsp_pio_pkg::IEN_IRQ]) |
               (siord_full & ~m_last_rd & m_pioc.ien[dsp_pio_pkg::IEN_SIORD]) |
               (siowr_empty & ~m_last_wr & m_pioc.ien[dsp_pio_pkg::IEN_SIOWR]);
    m_latch     = rise_any & ~ack_fall;
    m_last_irq  = irq & ~ack_fall; // ack re-arms a held irq
    m_last_rd   = siord_full;
    m_last_wr   = siowr_empty;
    m_last_iack = iack;
    if (cen) begin
        len = int'(m_pioc.stlen) + 1;
        if (m_pi_left == 1) begin // edge ending the last low tick
            if (m_psel) begin
                m_pdx1 = bus_word;
            end else begin
                m_pdx0 = bus_word;
            end
        end
        if (m_po_left > 0) m_po_left = m_po_left - 1;
        if (m_pi_left > 0) m_pi_left = m_pi_left - 1;
        if (req.op == dsp_pio_pkg::OP_LOAD && req.sel == dsp_pio_pkg::REG_PIOC) begin
            m_pioc = req.data[14:5];
        end else if (req.op != dsp_pio_pkg::OP_NONE && req.sel != dsp_pio_pkg::REG_PIOC) begin
            m_psel = (req.sel == dsp_pio_pkg::REG_PDX1);
            if (req.op == dsp_pio_pkg::OP_LOAD) begin
                m_pbus_out = req.data;
                m_po_left  = len; // restarts a running strobe
            end else begin
                m_pi_left  = len;
            end
        end
    end
endtask

// read-back word for the current rd_sel
function automatic logic [15:0] expected_dout();
    logic [4:0] st;
    st = {siowr_empty, siord_full, 2'b00, irq & m_pioc.ien[dsp_pio_pkg::IEN_IRQ]};
    case (rd_sel)
        dsp_pio_pkg::REG_PIOC: return {st[4], m_pioc, st};
        dsp_pio_pkg::REG_PDX0: return m_pdx0;
        default:               return m_pdx1;
    endcase
endfunction

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

`endif

//--- verif/pio_tb.sv
`timescale 1ns/1ps

module pio_tb;

    logic                  clk;
    logic                  rst;
    logic                  cen;
    dsp_pio_pkg::pio_req_t req;
    dsp_pio_pkg::pio_reg_e rd_sel;
    logic [15:0]           pbus_in;
    logic                  irq;
    logic                  siord_full;
    logic                  siowr_empty;
    logic                  iack;
    logic [15:0]           pbus_out;
    logic                  pods_n;
    logic                  pids_n;
    logic                  psel;
    logic [15:0]           pio_dout;
    logic                  irq_latch;

    int          seed;
    logic [15:0] bus_word; // value the peripheral puts on pbus_in

    pio_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .req         (req),
        .rd_sel      (rd_sel),
        .pio_dout    (pio_dout),
        .pbus_in     (pbus_in),
        .pbus_out    (pbus_out),
        .pods_n      (pods_n),
        .pids_n      (pids_n),
        .psel        (psel),
        .irq         (irq),
        .siord_full  (siord_full),
        .siowr_empty (siowr_empty),
        .iack        (iack),
        .irq_latch   (irq_latch)
    );

    always #10 clk = ~clk; // 20 ns period

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "run stopped on first error");
    endtask

    `include "pio_model.svh"

    function automatic logic [1:0] pick_reg(input logic [31:0] r);
        logic [31:0] m;
        m = r % 32'd3; // pioc, pdx0 or pdx1
        return m[1:0];
    endfunction

    task automatic compare_outputs();
        check_value("pbus_out", pbus_out, m_pbus_out);
        check_value("pods_n", {15'd0, pods_n}, {15'd0, m_po_left == 0});
        check_value("pids_n", {15'd0, pids_n}, {15'd0, m_pi_left == 0});
        check_value("psel", {15'd0, psel}, {15'd0, m_psel});
        check_value("irq_latch", {15'd0, irq_latch}, {15'd0, m_latch});
        check_value("pio_dout", pio_dout, expected_dout());
    endtask

    // new inputs on the falling edge
    task automatic drive_inputs(input bit allow_req);
        logic [31:0] r;
        logic [31:0] d;
        r = $random(seed);
        d = $random(seed);
        cen    = r[0];
        req    = '0;
        req.op = dsp_pio_pkg::OP_NONE;
        if (allow_req && cen && r[3:2] == 2'd0) begin // about one cen tick in four
            req.data = d[15:0];
            if (r[7:4] < 4'd2) begin
                req.op  = dsp_pio_pkg::OP_LOAD; // control load
                req.sel = dsp_pio_pkg::REG_PIOC;
            end else begin
                req.op  = (r[7:4] < 4'd9) ? dsp_pio_pkg::OP_LOAD : dsp_pio_pkg::OP_READ;
                req.sel = r[8] ? dsp_pio_pkg::REG_PDX1 : dsp_pio_pkg::REG_PDX0;
                if (r[7:4] == 4'hf) req.sel = dsp_pio_pkg::REG_PIOC; // ignored read
            end
        end
        rd_sel = dsp_pio_pkg::pio_reg_e'(pick_reg(d));
        if (r[13:11] == 3'd0) irq = ~irq;         // slow random edges
        if (r[16:14] == 3'd0) siord_full = ~siord_full;
        if (r[19:17] == 3'd0) siowr_empty = ~siowr_empty;
        if (r[22:20] == 3'd0) iack = ~iack;
        if (pids_n == 1'b0) begin // peripheral answers a read
            bus_word = d[31:16];
            pbus_in  = bus_word;
        end
    endtask

    task automatic run_cycle(input bit allow_req);
        @(posedge clk);
        step_model();
        @(negedge clk);
        compare_outputs();
        drive_inputs(allow_req);
    endtask

    task automatic wait_strobes_idle(input int limit);
        int n;
        n = 0;
        while (pods_n !== 1'b1 || pids_n !== 1'b1) begin
            if (n >= limit) begin
                $display("timeout: strobes still low after %0d cycles", limit);
                stop_run();
            end else begin
                run_cycle(1'b0);
                n++;
            end
        end
    endtask

    initial begin
        int cyc;
        seed        = 32'h302c_b716;
        clk         = 1'b0;
        rst         = 1'b1;
        cen         = 1'b0;
        req         = '0;
        req.op      = dsp_pio_pkg::OP_NONE;
        rd_sel      = dsp_pio_pkg::REG_PIOC; // reset read-back
        bus_word    = 16'd0;
        pbus_in     = 16'd0;
        irq         = 1'b0;
        siord_full  = 1'b0;
        siowr_empty = 1'b0;
        iack        = 1'b0;
        reset_model();
        repeat (5) begin
            @(negedge clk);
            compare_outputs();
        end
        rst = 1'b0;
        for (cyc = 0; cyc < 3000; cyc++) begin
            run_cycle(1'b1);
        end
        wait_strobes_idle(64);
        $display("Verification passed");
        $finish;
    end

endmodule
